//--- hdl/rv_pkg.sv
package rv_pkg;

    ////////////////////
    // widths and depths
    ////////////////////
    localparam int xlen       = 32;
    localparam int imem_words = 256;              // program store, in words
    localparam int imem_aw    = $clog2(imem_words);
    localparam int dmem_bytes = 1024;             // data store, in bytes
    localparam int dmem_aw    = $clog2(dmem_bytes);

    typedef logic [xlen-1:0]    word_t;           // data, address or instruction
    typedef logic [4:0]         reg_idx_t;
    typedef logic [imem_aw-1:0] imem_addr_t;      // word index
    typedef logic [dmem_aw-1:0] dmem_addr_t;      // byte index

    // opcode groups, instr[6:2]
    typedef enum logic [4:0] {
        opc_load   = 5'b00000,
        opc_op_imm = 5'b00100,
        opc_auipc  = 5'b00101,
        opc_store  = 5'b01000,
        opc_op     = 5'b01100,
        opc_lui    = 5'b01101,
        opc_branch = 5'b11000,
        opc_jalr   = 5'b11001,
        opc_jal    = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
        alu_pass_b                                // lui
    } alu_op_e;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_sel_e;

    typedef enum logic [1:0] {wb_mem, wb_alu, wb_pc4} wb_sel_e;

    ////////////////////
    // control word
    ////////////////////
    typedef struct packed {
        logic       reg_we;
        imm_sel_e   imm_sel;
        logic       br_unsigned;
        logic       a_sel;        // 0 rs1, 1 pc
        logic       b_sel;        // 0 rs2, 1 imm
        alu_op_e    alu_op;
        logic       mem_rd;
        logic       mem_wr;
        logic [2:0] mem_size;     // funct3 of load/store
        wb_sel_e    wb_sel;
        logic       is_branch;
        logic       is_jump;
    } ctrl_t;

    // no register write, no store, no jump
    localparam ctrl_t ctrl_nop = '{
        reg_we: 1'b0, imm_sel: imm_i, br_unsigned: 1'b0, a_sel: 1'b0, b_sel: 1'b0,
        alu_op: alu_add, mem_rd: 1'b0, mem_wr: 1'b0, mem_size: 3'b010,
        wb_sel: wb_alu, is_branch: 1'b0, is_jump: 1'b0
    };

    // reports
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    typedef struct packed {
        logic       valid;
        word_t      addr;         // word aligned
        word_t      data;         // already placed in its byte lanes
        logic [3:0] byte_en;
    } store_t;

endpackage

//--- hdl/rv_fetch.sv
`timescale 1ns/100ps

module rv_fetch (
    input  logic               clk,
    input  logic               reset,
    input  logic               run,
    // program load
    input  logic               imem_wr,
    input  rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::word_t      imem_data,
    // next pc choice
    input  logic               pc_sel,
    input  rv_pkg::word_t      alu_out,
    output rv_pkg::word_t      pc,
    output rv_pkg::word_t      instr
);

    rv_pkg::word_t      imem [rv_pkg::imem_words];
    rv_pkg::imem_addr_t pc_word;   // pc as word index
    rv_pkg::word_t      pc_next;

    ////////////////////
    // instruction memory
    ////////////////////
    always_ff @(posedge clk) begin
        if (imem_wr) begin
            imem[imem_addr] <= imem_data;   // one word per strobe
        end
    end

    assign pc_word = pc[rv_pkg::imem_aw+1:2];
    assign instr   = imem[pc_word];         // async read

    ////////////////////
    // program counter
    ////////////////////
    // jalr target has bit 0 dropped, branch/jal targets are even anyway
    assign pc_next = pc_sel ? {alu_out[31:1], 1'b0} : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
        end
        // run low holds pc
    end

endmodule

//--- hdl/rv_control.sv
`timescale 1ns/100ps

module rv_control (
    input  rv_pkg::word_t instr,
    input  logic          br_eq,
    input  logic          br_lt,
    output rv_pkg::ctrl_t ctrl,
    output logic          pc_sel
);

    logic [8:0] nbi;      // {funct7[5], funct3, opcode[6:2]}
    logic [2:0] funct3;

    assign funct3 = instr[14:12];
    assign nbi    = {instr[30], funct3, instr[6:2]};

    // register/immediate alu op writing rd from the alu
    function automatic rv_pkg::ctrl_t alu_ctl(input rv_pkg::alu_op_e op, input logic use_imm);
        rv_pkg::ctrl_t c;
        c         = rv_pkg::ctrl_nop;
        c.reg_we  = 1'b1;
        c.imm_sel = rv_pkg::imm_i;
        c.b_sel   = use_imm;
        c.alu_op  = op;
        c.wb_sel  = rv_pkg::wb_alu;
        return c;
    endfunction

    ////////////////////
    // decode table
    ////////////////////
    always_comb begin
        ctrl = rv_pkg::ctrl_nop;            // unknown -> no writes
        casez (nbi)
            // r-type
            {1'b0, 3'b000, rv_pkg::opc_op}: ctrl = alu_ctl(rv_pkg::alu_add, 1'b0);
            {1'b1, 3'b000, rv_pkg::opc_op}: ctrl = alu_ctl(rv_pkg::alu_sub, 1'b0);
            {1'b0, 3'b111, rv_pkg::opc_op}: ctrl = alu_ctl(rv_pkg::alu_and, 1'b0);
            {1'b0, 3'b110, rv_pkg::opc_op}: ctrl = alu_ctl(rv_pkg::alu_or, 1'b0);
            {1'b0, 3'b100, rv_pkg::opc_op}: ctrl = alu_ctl(rv_pkg::alu_xor, 1'b0);
            {1'b0, 3'b001, rv_pkg::opc_op}: ctrl = alu_ctl(rv_pkg::alu_sll, 1'b0);
            {1'b0, 3'b101, rv_pkg::opc_op}: ctrl = alu_ctl(rv_pkg::alu_srl, 1'b0);
            {1'b1, 3'b101, rv_pkg::opc_op}: ctrl = alu_ctl(rv_pkg::alu_sra, 1'b0);
            {1'b0, 3'b010, rv_pkg::opc_op}: ctrl = alu_ctl(rv_pkg::alu_slt, 1'b0);
            {1'b0, 3'b011, rv_pkg::opc_op}: ctrl = alu_ctl(rv_pkg::alu_sltu, 1'b0);

            // i-type, bit 30 is immediate except for the shifts
            {1'b?, 3'b000, rv_pkg::opc_op_imm}: ctrl = alu_ctl(rv_pkg::alu_add, 1'b1);
            {1'b?, 3'b111, rv_pkg::opc_op_imm}: ctrl = alu_ctl(rv_pkg::alu_and, 1'b1);
            {1'b?, 3'b110, rv_pkg::opc_op_imm}: ctrl = alu_ctl(rv_pkg::alu_or, 1'b1);
            {1'b?, 3'b100, rv_pkg::opc_op_imm}: ctrl = alu_ctl(rv_pkg::alu_xor, 1'b1);
            {1'b0, 3'b001, rv_pkg::opc_op_imm}: ctrl = alu_ctl(rv_pkg::alu_sll, 1'b1);
            {1'b0, 3'b101, rv_pkg::opc_op_imm}: ctrl = alu_ctl(rv_pkg::alu_srl, 1'b1);
            {1'b1, 3'b101, rv_pkg::opc_op_imm}: ctrl = alu_ctl(rv_pkg::alu_sra, 1'b1);
            {1'b?, 3'b010, rv_pkg::opc_op_imm}: ctrl = alu_ctl(rv_pkg::alu_slt, 1'b1);
            {1'b?, 3'b011, rv_pkg::opc_op_imm}: ctrl = alu_ctl(rv_pkg::alu_sltu, 1'b1);

            // loads, size and sign handled in memory
            {1'b?, 3'b000, rv_pkg::opc_load},
            {1'b?, 3'b001, rv_pkg::opc_load},
            {1'b?, 3'b010, rv_pkg::opc_load},
            {1'b?, 3'b100, rv_pkg::opc_load},
            {1'b?, 3'b101, rv_pkg::opc_load}: begin
                ctrl          = alu_ctl(rv_pkg::alu_add, 1'b1);
                ctrl.mem_rd   = 1'b1;
                ctrl.mem_size = funct3;
                ctrl.wb_sel   = rv_pkg::wb_mem;
            end

            // stores: rs1 + s-imm
            {1'b?, 3'b000, rv_pkg::opc_store},
            {1'b?, 3'b001, rv_pkg::opc_store},
            {1'b?, 3'b010, rv_pkg::opc_store}: begin
                ctrl.imm_sel  = rv_pkg::imm_s;
                ctrl.b_sel    = 1'b1;
                ctrl.mem_wr   = 1'b1;
                ctrl.mem_size = funct3;
            end

            // branches: alu makes pc + b-imm, comparator decides
            {1'b?, 3'b000, rv_pkg::opc_branch},
            {1'b?, 3'b001, rv_pkg::opc_branch},
            {1'b?, 3'b100, rv_pkg::opc_branch},
            {1'b?, 3'b101, rv_pkg::opc_branch},
            {1'b?, 3'b110, rv_pkg::opc_branch},
            {1'b?, 3'b111, rv_pkg::opc_branch}: begin
                ctrl.imm_sel     = rv_pkg::imm_b;
                ctrl.br_unsigned = funct3[1];   // bltu, bgeu
                ctrl.a_sel       = 1'b1;
                ctrl.b_sel       = 1'b1;
                ctrl.is_branch   = 1'b1;
            end

            {1'b?, 3'b???, rv_pkg::opc_jal},
            {1'b?, 3'b000, rv_pkg::opc_jalr}: begin
                ctrl         = alu_ctl(rv_pkg::alu_add, 1'b1);
                ctrl.imm_sel = (instr[3]) ? rv_pkg::imm_j : rv_pkg::imm_i;
                ctrl.a_sel   = instr[3];        // jal is pc relative
                ctrl.wb_sel  = rv_pkg::wb_pc4;  // link
                ctrl.is_jump = 1'b1;
            end

            {1'b?, 3'b???, rv_pkg::opc_auipc}: begin
                ctrl         = alu_ctl(rv_pkg::alu_add, 1'b1);
                ctrl.imm_sel = rv_pkg::imm_u;
                ctrl.a_sel   = 1'b1;
            end
            {1'b?, 3'b???, rv_pkg::opc_lui}: begin
                ctrl         = alu_ctl(rv_pkg::alu_pass_b, 1'b1);
                ctrl.imm_sel = rv_pkg::imm_u;
            end
            default: ctrl = rv_pkg::ctrl_nop;
        endcase
    end

    ////////////////////
    // branch resolve
    ////////////////////
    always_comb begin
        pc_sel = 1'b0;
        if (ctrl.is_jump) begin
            pc_sel = 1'b1;                  // jal, jalr
        end else if (ctrl.is_branch) begin
            case (funct3)
                3'b000:         pc_sel = br_eq;     // beq
                3'b001:         pc_sel = !br_eq;    // bne
                3'b100, 3'b110: pc_sel = br_lt;     // blt, bltu
                3'b101, 3'b111: pc_sel = !br_lt;    // bge, bgeu
                default:        pc_sel = 1'b0;
            endcase
        end
    end

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/100ps

module rv_decode (
    input  logic          clk,
    input  logic          reset,
    input  logic          run,
    input  rv_pkg::word_t instr,
    input  rv_pkg::ctrl_t ctrl,
    input  rv_pkg::word_t wb_data,
    output rv_pkg::word_t rs1_val,
    output rv_pkg::word_t rs2_val,
    output rv_pkg::word_t imm,
    output logic          br_eq,
    output logic          br_lt
);

    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    regs [1:31];    // x0 not stored

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    ////////////////////
    // register file
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (run && ctrl.reg_we && rd != 5'd0) begin
            regs[rd] <= wb_data;        // written at end of cycle
        end
    end

    // async reads, x0 hardwired
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    ////////////////////
    // immediates
    ////////////////////
    always_comb begin
        case (ctrl.imm_sel)
            rv_pkg::imm_i: imm = {{20{instr[31]}}, instr[31:20]};
            rv_pkg::imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // b and j scramble the offset bits, lsb always 0
            rv_pkg::imm_b: imm = {{19{instr[31]}}, instr[31], instr[7],
                                  instr[30:25], instr[11:8], 1'b0};
            rv_pkg::imm_u: imm = {instr[31:12], 12'b0};
            rv_pkg::imm_j: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                  instr[20], instr[30:21], 1'b0};
            default:       imm = '0;
        endcase
    end

    ////////////////////
    // branch compare
    ////////////////////
    assign br_eq = (rs1_val == rs2_val);

    always_comb begin
        if (ctrl.br_unsigned) begin
            br_lt = (rs1_val < rs2_val);
        end else begin
            br_lt = ($signed(rs1_val) < $signed(rs2_val));
        end
    end

endmodule

//--- hdl/rv_execute.sv
`timescale 1ns/100ps

module rv_execute (
    input  rv_pkg::ctrl_t ctrl,
    input  rv_pkg::word_t pc,
    input  rv_pkg::word_t rs1_val,
    input  rv_pkg::word_t rs2_val,
    input  rv_pkg::word_t imm,
    output rv_pkg::word_t alu_out
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    logic [4:0]    shamt;

    ////////////////////
    // operand select
    ////////////////////
    assign op_a  = ctrl.a_sel ? pc : rs1_val;     // pc for branch, jal, auipc
    assign op_b  = ctrl.b_sel ? imm : rs2_val;
    assign shamt = op_b[4:0];                     // only low 5 bits shift

    ////////////////////
    // alu
    ////////////////////
    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::alu_add:    alu_out = op_a + op_b;
            rv_pkg::alu_sub:    alu_out = op_a - op_b;
            rv_pkg::alu_and:    alu_out = op_a & op_b;
            rv_pkg::alu_or:     alu_out = op_a | op_b;
            rv_pkg::alu_xor:    alu_out = op_a ^ op_b;
            rv_pkg::alu_sll:    alu_out = op_a << shamt;
            rv_pkg::alu_srl:    alu_out = op_a >> shamt;
            rv_pkg::alu_sra:    alu_out = $signed(op_a) >>> shamt;   // sign fill
            rv_pkg::alu_slt: begin
                alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            rv_pkg::alu_sltu: begin
                alu_out = {31'b0, op_a < op_b};
            end
            // lui, imm already shifted up
            rv_pkg::alu_pass_b: alu_out = op_b;
            default:            alu_out = op_a + op_b;
        endcase
    end

endmodule

//--- hdl/rv_memory.sv
`timescale 1ns/100ps

module rv_memory (
    input  logic            clk,
    input  logic            run,
    input  rv_pkg::ctrl_t   ctrl,
    input  rv_pkg::word_t   instr,
    input  rv_pkg::word_t   alu_out,
    input  rv_pkg::word_t   rs2_val,
    input  rv_pkg::word_t   pc,
    output rv_pkg::word_t   wb_data,
    output rv_pkg::retire_t retire,
    output rv_pkg::store_t  store
);

    logic [7:0]         dmem [rv_pkg::dmem_bytes];
    rv_pkg::dmem_addr_t addr;
    logic [1:0]         lane;         // byte within word
    logic [3:0]         size_mask;
    rv_pkg::word_t      rd_word;
    rv_pkg::word_t      rd_shift;
    rv_pkg::word_t      load_data;

    assign addr = alu_out[rv_pkg::dmem_aw-1:0];
    assign lane = addr[1:0];

    ////////////////////
    // store path
    ////////////////////
    always_comb begin
        case (ctrl.mem_size[1:0])
            2'b00:   size_mask = 4'b0001;    // sb
            2'b01:   size_mask = 4'b0011;    // sh
            default: size_mask = 4'b1111;    // sw
        endcase
    end

    assign store.valid   = run & ctrl.mem_wr;
    assign store.addr    = {alu_out[31:2], 2'b00};
    assign store.data    = rs2_val << {lane, 3'b000};
    assign store.byte_en = size_mask << lane;

    always_ff @(posedge clk) begin
        if (store.valid) begin
            for (int i = 0; i < 4; i++) begin
                if (store.byte_en[i]) begin
                    dmem[{addr[rv_pkg::dmem_aw-1:2], 2'(i)}] <= store.data[8*i +: 8];
                end
            end
        end
    end

    ////////////////////
    // load path
    ////////////////////
    assign rd_word  = {dmem[{addr[rv_pkg::dmem_aw-1:2], 2'd3}],
                       dmem[{addr[rv_pkg::dmem_aw-1:2], 2'd2}],
                       dmem[{addr[rv_pkg::dmem_aw-1:2], 2'd1}],
                       dmem[{addr[rv_pkg::dmem_aw-1:2], 2'd0}]};
    assign rd_shift = rd_word >> {lane, 3'b000};   // addressed byte to bit 0

    always_comb begin
        load_data = '0;
        if (ctrl.mem_rd) begin
            case (ctrl.mem_size)
                3'b000:  load_data = {{24{rd_shift[7]}}, rd_shift[7:0]};     // lb
                3'b001:  load_data = {{16{rd_shift[15]}}, rd_shift[15:0]};   // lh
                3'b100:  load_data = {24'b0, rd_shift[7:0]};                 // lbu
                3'b101:  load_data = {16'b0, rd_shift[15:0]};                // lhu
                default: load_data = rd_shift;                               // lw
            endcase
        end
    end

    ////////////////////
    // writeback and retire report
    ////////////////////
    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::wb_mem: wb_data = load_data;
            rv_pkg::wb_pc4: wb_data = pc + 32'd4;     // jal/jalr link
            default:        wb_data = alu_out;
        endcase
    end

    assign retire.rd    = instr[11:7];
    assign retire.data  = wb_data;
    // same qualification as the register file write
    assign retire.valid = run & ctrl.reg_we & (instr[11:7] != 5'd0);

endmodule

//--- hdl/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               run,
    input  logic               imem_wr,
    input  rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::word_t      imem_data,
    output rv_pkg::retire_t    retire,
    output rv_pkg::store_t     store
);

    rv_pkg::word_t instr;
    rv_pkg::word_t pc;
    rv_pkg::ctrl_t ctrl;
    logic          pc_sel;
    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    rv_pkg::word_t imm;
    logic          br_eq;
    logic          br_lt;
    rv_pkg::word_t alu_out;
    rv_pkg::word_t wb_data;    // loops back to the regfile

    ////////////////////
    // input side
    ////////////////////
    rv_fetch u_rv_fetch (
        .clk(clk), .reset(reset), .run(run),
        .imem_wr(imem_wr), .imem_addr(imem_addr), .imem_data(imem_data),
        .pc_sel(pc_sel), .alu_out(alu_out), .pc(pc), .instr(instr)
    );

    ////////////////////
    // processing
    ////////////////////
    rv_control u_rv_control (
        .instr(instr), .br_eq(br_eq), .br_lt(br_lt), .ctrl(ctrl), .pc_sel(pc_sel)
    );

    rv_decode u_rv_decode (
        .clk(clk), .reset(reset), .run(run), .instr(instr), .ctrl(ctrl),
        .wb_data(wb_data), .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm),
        .br_eq(br_eq), .br_lt(br_lt)
    );

    rv_execute u_rv_execute (
        .ctrl(ctrl), .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val), .imm(imm),
        .alu_out(alu_out)
    );

    ////////////////////
    // output side
    ////////////////////
    rv_memory u_rv_memory (
        .clk(clk), .run(run), .ctrl(ctrl), .instr(instr), .alu_out(alu_out),
        .rs2_val(rs2_val), .pc(pc), .wb_data(wb_data), .retire(retire), .store(store)
    );

endmodule

//--- dv/rv_core_tb_prog.svh
localparam int prog_len = 67;

// instruction word and the event it reports when it runs
// rows skipped by a taken branch or jump carry no event
step_t steps [prog_len] = '{
    '{i_type(0, 1, 0, 5, op_imm), writes(1, 5)},                       // addi x1, x0, 5
    '{i_type(0, 2, 0, -3, op_imm), writes(2, 32'hffff_fffd)},          // addi x2, x0, -3
    '{r_type(0, 0, 3, 1, 2), writes(3, 2)},                            // add
    '{r_type('h20, 0, 4, 1, 2), writes(4, 8)},                         // sub
    '{r_type(0, 7, 5, 1, 2), writes(5, 5)},                            // and
    '{r_type(0, 6, 6, 1, 2), writes(6, 32'hffff_fffd)},                // or
    '{r_type(0, 4, 7, 1, 2), writes(7, 32'hffff_fff8)},                // xor
    '{r_type(0, 1, 8, 1, 1), writes(8, 'ha0)},                         // sll by 5
    '{r_type(0, 5, 9, 2, 1), writes(9, 32'h07ff_ffff)},                // srl
    '{r_type('h20, 5, 11, 2, 1), writes(11, 32'hffff_ffff)},           // sra
    '{r_type(0, 2, 12, 2, 1), writes(12, 1)},                          // slt -3 < 5
    '{r_type(0, 3, 13, 2, 1), writes(13, 0)},                          // sltu
    '{i_type(1, 14, 1, 3, op_imm), writes(14, 'h28)},                  // slli
    '{i_type(5, 15, 2, 28, op_imm), writes(15, 'hf)},                  // srli
    '{i_type(5, 16, 2, 'h401, op_imm), writes(16, 32'hffff_fffe)},     // srai by 1
    '{i_type(2, 17, 2, -2, op_imm), writes(17, 1)},                    // slti
    '{i_type(3, 18, 1, -1, op_imm), writes(18, 1)},                    // sltiu
    '{i_type(7, 19, 2, 'hf0, op_imm), writes(19, 'hf0)},               // andi
    '{i_type(6, 20, 1, 'h700, op_imm), writes(20, 'h705)},             // ori
    '{i_type(4, 21, 1, -1, op_imm), writes(21, 32'hffff_fffa)},        // xori
    '{i_type(0, 0, 1, 7, op_imm), no_event()},                         // write to x0
    '{r_type(0, 0, 22, 0, 1), writes(22, 5)},                          // x0 still 0
    '{u_type(op_lui, 23, 'h12345), writes(23, 32'h1234_5000)},
    '{i_type(0, 10, 0, 256, op_imm), writes(10, 'h100)},               // data base
    '{u_type(op_lui, 25, 'h89abd), writes(25, 32'h89ab_d000)},
    '{i_type(0, 25, 25, -529, op_imm), writes(25, 32'h89ab_cdef)},
    '{s_type(2, 25, 10, 0), stores('h100, 32'h89ab_cdef, 'hf)},        // sw
    '{s_type(0, 25, 10, 5), stores('h104, 32'habcd_ef00, 'h2)},        // sb lane 1
    '{s_type(1, 25, 10, 10), stores('h108, 32'hcdef_0000, 'hc)},       // sh lanes 2,3
    '{i_type(0, 26, 10, 3, op_load), writes(26, 32'hffff_ff89)},       // lb
    '{i_type(4, 27, 10, 3, op_load), writes(27, 'h89)},                // lbu
    '{i_type(1, 28, 10, 2, op_load), writes(28, 32'hffff_89ab)},       // lh
    '{i_type(5, 29, 10, 10, op_load), writes(29, 'hcdef)},             // lhu
    '{i_type(2, 30, 10, 0, op_load), writes(30, 32'h89ab_cdef)},       // lw
    '{i_type(0, 31, 10, 5, op_load), writes(31, 32'hffff_ffef)},       // lb of sb byte
    '{b_type(0, 1, 22, 8), no_event()},                                // beq taken
    '{i_type(0, 24, 0, 1, op_imm), no_event()},
    '{b_type(0, 1, 2, 8), no_event()},                                 // beq not taken
    '{i_type(0, 24, 0, 2, op_imm), writes(24, 2)},
    '{b_type(1, 1, 2, 8), no_event()},                                 // bne taken
    '{i_type(0, 24, 0, 3, op_imm), no_event()},
    '{b_type(1, 1, 22, 8), no_event()},                                // bne not taken
    '{i_type(0, 24, 0, 4, op_imm), writes(24, 4)},
    '{b_type(4, 2, 1, 8), no_event()},                                 // blt taken
    '{i_type(0, 24, 0, 5, op_imm), no_event()},
    '{b_type(4, 1, 2, 8), no_event()},                                 // blt not taken
    '{i_type(0, 24, 0, 6, op_imm), writes(24, 6)},
    '{b_type(5, 1, 2, 8), no_event()},                                 // bge taken
    '{i_type(0, 24, 0, 7, op_imm), no_event()},
    '{b_type(5, 2, 1, 8), no_event()},                                 // bge not taken
    '{i_type(0, 24, 0, 8, op_imm), writes(24, 8)},
    '{b_type(6, 1, 2, 8), no_event()},                                 // bltu taken
    '{i_type(0, 24, 0, 9, op_imm), no_event()},
    '{b_type(6, 2, 1, 8), no_event()},                                 // bltu not taken
    '{i_type(0, 24, 0, 10, op_imm), writes(24, 10)},
    '{b_type(7, 2, 1, 8), no_event()},                                 // bgeu taken
    '{i_type(0, 24, 0, 11, op_imm), no_event()},
    '{b_type(7, 1, 2, 8), no_event()},                                 // bgeu not taken
    '{i_type(0, 24, 0, 12, op_imm), writes(24, 12)},
    '{j_type(5, 8), writes(5, 'hf0)},                                  // jal links pc+4
    '{i_type(0, 24, 0, 13, op_imm), no_event()},
    '{u_type(op_auipc, 6, 1), writes(6, 'h10f4)},                      // pc 0xf4 + 0x1000
    '{i_type(0, 7, 0, 256, op_imm), writes(7, 'h100)},
    '{i_type(0, 8, 7, 5, op_jalr), writes(8, 'h100)},                  // odd target 0x105
    '{i_type(0, 24, 0, 14, op_imm), no_event()},
    '{u_type(op_auipc, 9, 0), writes(9, 'h104)},                       // pc with bit 0 cleared
    '{j_type(0, 0), no_event()}                                        // jal x0 to itself
};

//--- dv/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;

    localparam int         clk_period = 20;
    localparam logic [1:0] ev_none    = 2'd0;
    localparam logic [1:0] ev_retire  = 2'd1;
    localparam logic [1:0] ev_store   = 2'd2;

    // opcodes that the table passes explicitly
    localparam int op_imm   = 'h13;
    localparam int op_load  = 'h03;
    localparam int op_jalr  = 'h67;
    localparam int op_lui   = 'h37;
    localparam int op_auipc = 'h17;

    typedef struct packed {
        logic [1:0]       kind;      // none, retire or store
        rv_pkg::reg_idx_t rd;
        rv_pkg::word_t    addr;
        rv_pkg::word_t    data;
        logic [3:0]       byte_en;
    } event_t;

    typedef struct packed {
        rv_pkg::word_t instr;
        event_t        ev;           // what this instruction reports, if it runs
    } step_t;

    logic               clk;
    logic               reset;
    logic               run;
    logic               imem_wr;
    rv_pkg::imem_addr_t imem_addr;
    rv_pkg::word_t      imem_data;
    rv_pkg::retire_t    retire;
    rv_pkg::store_t     store;

    event_t expected [$];            // events still to come, in order
    int     n_expected     = 0;
    int     matched        = 0;
    int     mismatch_count = 0;
    int     other_errors   = 0;

    ////////////////////
    // instruction encoders, asm operand order
    ////////////////////
    function automatic rv_pkg::word_t r_type(input int f7, input int f3, input int rd,
                                             input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic rv_pkg::word_t i_type(input int f3, input int rd, input int rs1,
                                             input int imm, input int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic rv_pkg::word_t s_type(input int f3, input int rs2, input int rs1,
                                             input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic rv_pkg::word_t b_type(input int f3, input int rs1, input int rs2,
                                             input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic rv_pkg::word_t u_type(input int opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc[6:0]};    // imm is the upper 20 bits
    endfunction

    function automatic rv_pkg::word_t j_type(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    ////////////////////
    // expected events
    ////////////////////
    function automatic event_t writes(input int rd, input int data);
        event_t e;
        e      = '0;
        e.kind = ev_retire;
        e.rd   = rd[4:0];
        e.data = data;
        return e;
    endfunction

    function automatic event_t stores(input int addr, input int data, input int be);
        event_t e;
        e         = '0;
        e.kind    = ev_store;
        e.addr    = addr;            // word aligned
        e.data    = data;            // in its byte lanes
        e.byte_en = be[3:0];
        return e;
    endfunction

    function automatic event_t no_event();
        return '0;
    endfunction

    `include "rv_core_tb_prog.svh"

    // reset, load, one idle cycle, worst case 4 cycles per word, short tail
    localparam int timeout_cycles = 10 + prog_len + 1 + prog_len * 4 + 4;

    rv_core_top u_rv_core_top (
        .clk(clk), .reset(reset), .run(run),
        .imem_wr(imem_wr), .imem_addr(imem_addr), .imem_data(imem_data),
        .retire(retire), .store(store)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input rv_pkg::word_t exp,
                                   input rv_pkg::word_t got);
        mismatch_count++;
        $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, got);
    endtask

    // compares one DUT report with the head of the expected list
    task automatic check_event(input event_t got);
        event_t e;
        if (expected.size() == 0) begin
            other_errors++;
            $display("%0d ns: report seen after all expected events were matched", $time);
        end else begin
            e = expected.pop_front();
            assert (got.kind == e.kind)
            else report_mismatch("event kind", 32'(e.kind), 32'(got.kind));
            if (got.kind == e.kind && e.kind == ev_retire) begin
                assert (got.rd == e.rd)
                else report_mismatch("retire.rd", 32'(e.rd), 32'(got.rd));
                assert (got.data == e.data)
                else report_mismatch("retire.data", e.data, got.data);
            end else if (got.kind == e.kind) begin
                assert (got.addr == e.addr)
                else report_mismatch("store.addr", e.addr, got.addr);
                assert (got.data == e.data)
                else report_mismatch("store.data", e.data, got.data);
                assert (got.byte_en == e.byte_en)
                else report_mismatch("store.byte_en", 32'(e.byte_en), 32'(got.byte_en));
            end
            matched++;
        end
    endtask

    ////////////////////
    // main flow
    ////////////////////
    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        imem_wr   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        for (int i = 0; i < prog_len; i++) begin
            if (steps[i].ev.kind != ev_none) begin
                expected.push_back(steps[i].ev);
            end
        end
        n_expected = expected.size();

        repeat (10) @(negedge clk);         // 10 rising edges in reset
        reset = 1'b0;

        for (int i = 0; i < prog_len; i++) begin
            imem_wr   = 1'b1;
            imem_addr = rv_pkg::imem_addr_t'(i);
            imem_data = steps[i].instr;
            @(negedge clk);
        end
        imem_wr = 1'b0;
        @(negedge clk);                     // idle cycle, run still low
        run = 1'b1;

        wait (matched == n_expected);
        repeat (4) @(negedge clk);          // self loop must stay quiet

        $display("mismatches: %0d, other errors: %0d", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    ////////////////////
    // report monitor
    ////////////////////
    initial begin
        event_t got;
        forever begin
            @(negedge clk);
            #(clk_period / 4);              // inputs settled, next edge retires this
            if (!run) begin
                assert (!retire.valid && !store.valid) else begin
                    other_errors++;
                    $display("%0d ns: report seen while run was low", $time);
                end
            end else begin
                if (retire.valid) begin
                    got      = '0;
                    got.kind = ev_retire;
                    got.rd   = retire.rd;
                    got.data = retire.data;
                    check_event(got);
                end
                if (store.valid) begin
                    got         = '0;
                    got.kind    = ev_store;
                    got.addr    = store.addr;
                    got.data    = store.data;
                    got.byte_en = store.byte_en;
                    check_event(got);
                end
            end
        end
    end

    // watchdog
    initial begin
        #(timeout_cycles * clk_period);
        $display("timeout: the expected events did not all occur, %0d of %0d matched",
                 matched, n_expected);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+dv
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_control.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/rv_core_top.sv
dv/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the rv_core testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sources.f --top-module rv_core_tb -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
